//--- hw/fat_pkg.sv
// shared constants, enums and packed structs for the FAT32 file reader
// imported by every RTL module and by the bench
package fat_pkg;

    localparam int SECTOR_BYTES    = 512;
    localparam int DIR_ENTRY_BYTES = 32;
    localparam int SHORT_NAME_LEN  = 11;

    localparam logic [15:0] BOOT_SIGNATURE = 16'h55AA;
    localparam logic [8:0]  BOOT_SIG_OFS   = 9'h1FE;  // 55 at 1FE, AA at 1FF

    // boot record field offsets, multi-byte fields are little endian
    localparam logic [8:0] JMP_OFS      = 9'h000;
    localparam logic [8:0] PART_LBA_OFS = 9'h1C6;  // first partition entry, start LBA
    localparam logic [8:0] BPS_OFS      = 9'h00B;
    localparam logic [8:0] SPC_OFS      = 9'h00D;
    localparam logic [8:0] RESV_OFS     = 9'h00E;
    localparam logic [8:0] NFATS_OFS    = 9'h010;
    localparam logic [8:0] SPF16_OFS    = 9'h016;
    localparam logic [8:0] SPF32_OFS    = 9'h024;
    localparam logic [8:0] ROOTCLUS_OFS = 9'h02C;
    localparam logic [8:0] FSTAG_OFS    = 9'h056;  // the "2" of "FAT32"

    // offsets inside a 32-byte directory entry
    localparam logic [4:0] ENT_CLUS_HI_OFS = 5'd20;
    localparam logic [4:0] ENT_CLUS_LO_OFS = 5'd26;
    localparam logic [4:0] ENT_SIZE_OFS    = 5'd28;

    localparam logic [31:0] FAT32_EOC_MIN = 32'h0FFF_FFF8;
    localparam logic [31:0] FAT32_MASK    = 32'h0FFF_FFFF;
    localparam logic [31:0] MIN_CLUSTER   = 32'd2;

    typedef logic [31:0] sector_no_t;
    typedef logic [31:0] cluster_t;

    // first character sits in the top byte, same order as a string literal
    typedef logic [SHORT_NAME_LEN-1:0][7:0] short_name_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_SEARCH_MBR,
        ST_SEARCH_DBR,
        ST_LS_ROOT,
        ST_READ_FILE,
        ST_DONE
    } fat_state_e;

    typedef enum logic [1:0] {
        FS_UNASSIGNED,
        FS_UNKNOWN,
        FS_FAT32
    } fs_type_e;

    typedef struct packed {
        logic       start;      // one-cycle strobe
        sector_no_t sector_no;
    } sector_req_t;

    typedef struct packed {
        logic       valid;
        logic [8:0] addr;
        logic [7:0] data;
    } sector_beat_t;

    typedef struct packed {
        logic        is_boot;
        logic        is_dbr;
        sector_no_t  part_lba;
        logic [15:0] bytes_per_sector;
        logic [7:0]  sec_per_cluster;
        logic [15:0] resv_sectors;
        logic [7:0]  num_fats;
        logic [31:0] sectors_per_fat;
        cluster_t    root_cluster;
        fs_type_e    fs;
    } boot_info_t;

    typedef struct packed {
        logic        found;
        cluster_t    cluster;
        logic [31:0] size;
    } dir_hit_t;

endpackage

//--- hw/boot_sector_parser.sv
// picks the FAT32-relevant fields out of a boot sector as it streams past
// and decodes them into boot_info_t for the walker
`timescale 1ns/10ps

module boot_sector_parser import fat_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  sector_beat_t beat,
    output boot_info_t   info
);

    logic [15:0] sig;      // {byte 1FE, byte 1FF}
    logic [7:0]  jmp;
    logic [31:0] part_lba;
    logic [15:0] bps;
    logic [7:0]  spc;
    logic [15:0] resv;
    logic [7:0]  nfats;
    logic [15:0] spf16;
    logic [31:0] spf32;
    logic [31:0] root_clus;
    logic [7:0]  fstag;

    // signature and jump byte decide validity, so they start cleared
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            sig <= '0;
            jmp <= '0;
        end else if (beat.valid) begin
            case (beat.addr)
                JMP_OFS:              jmp       <= beat.data;
                BOOT_SIG_OFS:         sig[15:8] <= beat.data;
                BOOT_SIG_OFS + 9'd1:  sig[7:0]  <= beat.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            case (beat.addr)
                PART_LBA_OFS:         part_lba[7:0]   <= beat.data;
                PART_LBA_OFS + 9'd1:  part_lba[15:8]  <= beat.data;
                PART_LBA_OFS + 9'd2:  part_lba[23:16] <= beat.data;
                PART_LBA_OFS + 9'd3:  part_lba[31:24] <= beat.data;
                BPS_OFS:              bps[7:0]        <= beat.data;
                BPS_OFS + 9'd1:       bps[15:8]       <= beat.data;
                SPC_OFS:              spc             <= beat.data;
                RESV_OFS:             resv[7:0]       <= beat.data;
                RESV_OFS + 9'd1:      resv[15:8]      <= beat.data;
                NFATS_OFS:            nfats           <= beat.data;
                SPF16_OFS:            spf16[7:0]      <= beat.data;
                SPF16_OFS + 9'd1:     spf16[15:8]     <= beat.data;
                SPF32_OFS:            spf32[7:0]      <= beat.data;
                SPF32_OFS + 9'd1:     spf32[15:8]     <= beat.data;
                SPF32_OFS + 9'd2:     spf32[23:16]    <= beat.data;
                SPF32_OFS + 9'd3:     spf32[31:24]    <= beat.data;
                ROOTCLUS_OFS:         root_clus[7:0]  <= beat.data;
                ROOTCLUS_OFS + 9'd1:  root_clus[15:8] <= beat.data;
                ROOTCLUS_OFS + 9'd2:  root_clus[23:16] <= beat.data;
                ROOTCLUS_OFS + 9'd3:  root_clus[31:24] <= beat.data;
                FSTAG_OFS:            fstag           <= beat.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        info.is_boot          = (sig == BOOT_SIGNATURE);
        info.is_dbr           = (jmp == 8'hEB) || (jmp == 8'hE9);
        info.part_lba         = part_lba;
        info.bytes_per_sector = bps;
        info.sec_per_cluster  = spc;
        info.resv_sectors     = resv;
        info.num_fats         = nfats;
        info.root_cluster     = root_clus;
        if (spf16 == 16'd0 && fstag == "2") begin
            info.fs              = FS_FAT32;
            info.sectors_per_fat = spf32;
        end else begin
            info.fs              = FS_UNKNOWN;  // FAT12/16 or garbage
            info.sectors_per_fat = {16'd0, spf16};
        end
    end

endmodule

//--- hw/dir_entry_matcher.sv
// collects 32-byte directory entries during root directory reads and
// compares each short name with the target, case-insensitive
`timescale 1ns/10ps

module dir_entry_matcher import fat_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  sector_beat_t beat,
    input  logic         dir_phase,
    input  short_name_t  target_name,
    output dir_hit_t     hit
);

    logic [DIR_ENTRY_BYTES-1:0][7:0] ent;  // indexed by entry byte offset
    logic                            take;
    logic                            last_byte;
    logic                            name_eq;
    logic                            slot_used;
    cluster_t                        ent_cluster;
    logic [31:0]                     ent_size;

    function automatic logic [7:0] to_upper(input logic [7:0] c);
        return (c >= "a" && c <= "z") ? (c & 8'hDF) : c;
    endfunction

    assign take      = beat.valid && dir_phase;
    assign last_byte = (beat.addr[4:0] == 5'(DIR_ENTRY_BYTES - 1));

    always_ff @(posedge clk) begin
        if (take) begin
            ent[beat.addr[4:0]] <= beat.data;
        end
    end

    always_comb begin
        name_eq = 1'b1;
        for (int i = 0; i < SHORT_NAME_LEN; i++) begin
            if (to_upper(ent[i]) != to_upper(target_name[SHORT_NAME_LEN-1-i])) begin
                name_eq = 1'b0;
            end
        end
    end

    assign slot_used   = (ent[0] != 8'h00) && (ent[0] != 8'hE5);  // end marker / deleted
    assign ent_cluster = {ent[ENT_CLUS_HI_OFS + 5'd1], ent[ENT_CLUS_HI_OFS],
                          ent[ENT_CLUS_LO_OFS + 5'd1], ent[ENT_CLUS_LO_OFS]};
    // top size byte is offset 31, still on the bus this cycle
    assign ent_size    = {beat.data, ent[ENT_SIZE_OFS + 5'd2],
                          ent[ENT_SIZE_OFS + 5'd1], ent[ENT_SIZE_OFS]};

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            hit <= '0;
        end else if (take && last_byte && name_eq && slot_used && !hit.found) begin
            hit.found   <= 1'b1;  // first match wins, held until reset
            hit.cluster <= ent_cluster;
            hit.size    <= ent_size;
        end
    end

endmodule

//--- hw/cluster_walker.sv
// FAT32 control FSM: finds the boot record, walks the root directory
// cluster chain, then walks the file's chain while the streamer outputs data
// one sector read outstanding at a time, FAT sectors are read between clusters
`timescale 1ns/10ps

module cluster_walker import fat_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  boot_info_t   info,
    input  dir_hit_t     hit,
    input  sector_beat_t beat,
    input  logic         sector_done,
    output sector_req_t  sector_req,
    output fat_state_e   state,
    output fs_type_e     fs_type,
    output logic         dir_phase,
    output logic         data_phase,
    output logic [31:0]  file_size
);

    logic        search_fat;     // current read is a FAT sector
    logic [7:0]  cluster_size;
    sector_no_t  first_fat;
    sector_no_t  first_data;     // already offset back by two clusters
    cluster_t    curr_cluster;
    logic [7:0]  clus_ofs;       // sector within the current cluster
    logic [31:0] fat_entry;
    cluster_t    next_cluster;
    logic        chain_end;
    sector_no_t  fat_sector;
    sector_no_t  geo_first_fat;
    sector_no_t  geo_first_data;

    function automatic sector_no_t data_sector(input sector_no_t base, input logic [7:0] spc,
                                               input cluster_t cl, input logic [7:0] ofs);
        return base + 32'(spc) * cl + 32'(ofs);
    endfunction

    // geometry from the volume record just read, the read sector is its LBA
    assign geo_first_fat  = sector_req.sector_no + 32'(info.resv_sectors);
    assign geo_first_data = geo_first_fat + info.sectors_per_fat * 32'(info.num_fats)
                            - 32'(info.sec_per_cluster) * 32'd2;

    assign fat_sector   = first_fat + (curr_cluster >> 7);  // 128 entries per sector
    assign next_cluster = fat_entry & FAT32_MASK;
    assign chain_end    = (next_cluster >= FAT32_EOC_MIN) || (next_cluster < MIN_CLUSTER);

    assign dir_phase  = (state == ST_LS_ROOT) && !search_fat;
    assign data_phase = (state == ST_READ_FILE) && !search_fat;

    // grab the 4-byte entry of the current cluster from the FAT sector
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            fat_entry <= '0;
        end else if (search_fat && beat.valid && beat.addr[8:2] == curr_cluster[6:0]) begin
            fat_entry[{beat.addr[1:0], 3'b000} +: 8] <= beat.data;
        end
    end

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state        <= ST_RESET;
            fs_type      <= FS_UNASSIGNED;
            sector_req   <= '0;
            search_fat   <= 1'b0;
            cluster_size <= '0;
            first_fat    <= '0;
            first_data   <= '0;
            curr_cluster <= '0;
            clus_ofs     <= '0;
            file_size    <= '0;
        end else begin
            sector_req.start <= 1'b0;
            if (sector_done) begin
                case (state)
                    ST_SEARCH_MBR: begin
                        sector_req.start <= 1'b1;
                        if (info.is_boot) begin
                            state <= ST_SEARCH_DBR;
                            if (!info.is_dbr) begin
                                sector_req.sector_no <= info.part_lba;  // MBR, go to partition
                            end
                        end else begin
                            sector_req.sector_no <= sector_req.sector_no + 32'd1;
                        end
                    end
                    ST_SEARCH_DBR: begin
                        if (!(info.is_boot && info.is_dbr) ||
                            info.bytes_per_sector != 16'(SECTOR_BYTES)) begin
                            state <= ST_DONE;
                        end else begin
                            fs_type <= info.fs;
                            if (info.fs != FS_FAT32) begin
                                state <= ST_DONE;
                            end else begin
                                cluster_size <= info.sec_per_cluster;
                                first_fat    <= geo_first_fat;
                                first_data   <= geo_first_data;
                                curr_cluster <= info.root_cluster;
                                clus_ofs     <= '0;
                                sector_req   <= '{start: 1'b1,
                                                  sector_no: data_sector(geo_first_data,
                                                      info.sec_per_cluster, info.root_cluster,
                                                      8'd0)};
                                state        <= ST_LS_ROOT;
                            end
                        end
                    end
                    ST_LS_ROOT, ST_READ_FILE: begin
                        if (search_fat) begin
                            search_fat <= 1'b0;
                            clus_ofs   <= '0;
                            if (chain_end) begin
                                state <= ST_DONE;
                            end else begin
                                curr_cluster <= next_cluster;
                                sector_req   <= '{start: 1'b1,
                                                  sector_no: data_sector(first_data,
                                                      cluster_size, next_cluster, 8'd0)};
                            end
                        end else if (state == ST_LS_ROOT && hit.found) begin
                            state        <= ST_READ_FILE;
                            curr_cluster <= hit.cluster;
                            file_size    <= hit.size;
                            clus_ofs     <= '0;
                            sector_req   <= '{start: 1'b1,
                                              sector_no: data_sector(first_data, cluster_size,
                                                                     hit.cluster, 8'd0)};
                        end else if (clus_ofs < cluster_size - 8'd1) begin
                            clus_ofs   <= clus_ofs + 8'd1;
                            sector_req <= '{start: 1'b1,
                                            sector_no: data_sector(first_data, cluster_size,
                                                                   curr_cluster, clus_ofs + 8'd1)};
                        end else begin
                            search_fat <= 1'b1;  // cluster exhausted, look up the next one
                            clus_ofs   <= '0;
                            sector_req <= '{start: 1'b1, sector_no: fat_sector};
                        end
                    end
                    default: ;
                endcase
            end else if (state == ST_RESET) begin
                state      <= ST_SEARCH_MBR;
                sector_req <= '{start: 1'b1, sector_no: '0};
            end
        end
    end

endmodule

//--- hw/file_byte_streamer.sv
// forwards data-sector bytes to the output while the walker reads the file,
// stopping once file_size bytes have gone out
`timescale 1ns/10ps

module file_byte_streamer import fat_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  sector_beat_t beat,
    input  logic         data_phase,
    input  logic [31:0]  file_size,
    output logic         out_valid,
    output logic [7:0]   out_byte
);

    logic [31:0] byte_ptr;  // bytes sent so far
    logic        accept;

    assign accept = beat.valid && data_phase && (byte_ptr < file_size);  // drops the tail

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            byte_ptr  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
            if (accept) begin
                byte_ptr <= byte_ptr + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_byte <= beat.data;
        end
    end

endmodule

//--- hw/fat_file_reader.sv
// top level of the FAT32 file reader, sits on a generic sector-read port
// and streams out the bytes of the file named by target_name
`timescale 1ns/10ps

module fat_file_reader import fat_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  short_name_t  target_name,
    output sector_req_t  sector_req,
    input  logic         sector_done,
    input  sector_beat_t beat,
    output fs_type_e     fs_type,
    output fat_state_e   fat_state,
    output logic         file_found,
    output logic         out_valid,
    output logic [7:0]   out_byte
);

    boot_info_t  info;
    dir_hit_t    hit;
    logic        dir_phase;
    logic        data_phase;
    logic [31:0] file_size;

    assign file_found = hit.found;

    boot_sector_parser i_boot_parser (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (beat),
        .info  (info)
    );

    dir_entry_matcher i_dir_matcher (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat        (beat),
        .dir_phase   (dir_phase),
        .target_name (target_name),
        .hit         (hit)
    );

    cluster_walker i_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .info        (info),
        .hit         (hit),
        .beat        (beat),
        .sector_done (sector_done),
        .sector_req  (sector_req),
        .state       (fat_state),
        .fs_type     (fs_type),
        .dir_phase   (dir_phase),
        .data_phase  (data_phase),
        .file_size   (file_size)
    );

    file_byte_streamer i_streamer (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat       (beat),
        .data_phase (data_phase),
        .file_size  (file_size),
        .out_valid  (out_valid),
        .out_byte   (out_byte)
    );

endmodule

//--- bench/sector_source_model.sv
// behavioral sector reader for the bench, serves a sparse disk image
// each start strobe gets 512 beats with random gaps, then a done pulse
`timescale 1ns/10ps

module sector_source_model import fat_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  sector_req_t  sector_req,
    output sector_beat_t beat,
    output logic         sector_done
);

    logic [7:0]  mem [logic [31:0]];  // byte address -> data, missing bytes read as 0
    logic        busy;
    sector_no_t  sector;
    logic [9:0]  idx;                 // next byte of the sector
    logic [1:0]  gap;                 // idle cycles before the next beat
    logic [31:0] rnd;

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] read_byte(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : 8'h00;
    endfunction

    task automatic write_byte(input logic [31:0] a, input logic [7:0] d);
        mem[a] = d;
    endtask

    task automatic clear_image();
        mem.delete();
    endtask

    always @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            busy        <= 1'b0;
            sector      <= '0;
            idx         <= '0;
            gap         <= '0;
            rnd         <= 32'h9dc0f4b1;
            beat        <= '0;
            sector_done <= 1'b0;
        end else begin
            beat.valid  <= 1'b0;
            sector_done <= 1'b0;
            if (sector_req.start) begin
                busy   <= 1'b1;
                sector <= sector_req.sector_no;
                idx    <= '0;
                gap    <= '0;
            end else if (busy) begin
                if (gap != 2'd0) begin
                    gap <= gap - 2'd1;
                end else if (idx == 10'd512) begin
                    sector_done <= 1'b1;  // always at least one cycle after the last beat
                    busy        <= 1'b0;
                end else begin
                    beat <= '{valid: 1'b1, addr: idx[8:0],
                              data: read_byte({sector[22:0], idx[8:0]})};
                    idx  <= idx + 10'd1;
                    rnd  <= lcg_step(rnd);
                    gap  <= rnd[17:16];
                end
            end
        end
    end

endmodule

//--- bench/fat_reader_sva.sv
// concurrent checks on the sector port, the output strobe and the final state
// bound into fat_file_reader from the testbench
`timescale 1ns/10ps

module fat_reader_sva import fat_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input sector_req_t sector_req,
    input logic        sector_done,
    input fat_state_e  fat_state,
    input logic        out_valid
);

    logic outstanding;  // a read was started and its done pulse not yet seen
    int   fail_count = 0;  // number of assertion failures

    always @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            outstanding <= 1'b0;
        end else if (sector_req.start) begin
            outstanding <= 1'b1;
        end else if (sector_done) begin
            outstanding <= 1'b0;
        end
    end

    no_overlap_read: assert property (@(posedge clk) disable iff (rst_n)
        sector_req.start |-> !outstanding)
        else begin
            $error("sector read started while another read is outstanding");
            fail_count++;
        end

    valid_in_read: assert property (@(posedge clk) disable iff (rst_n)
        out_valid |-> (fat_state == ST_READ_FILE) || ($past(fat_state) == ST_READ_FILE))
        else begin
            $error("out_valid high outside of the file read");
            fail_count++;
        end

    done_is_final: assert property (@(posedge clk) disable iff (rst_n)
        (fat_state == ST_DONE) |=> (fat_state == ST_DONE))
        else begin
            $error("fat_state left ST_DONE without a reset");
            fail_count++;
        end

endmodule

//--- bench/tb_fat_file_reader.sv
// table-driven testbench for fat_file_reader
// builds a FAT32 image per row in the sector model and runs it to ST_DONE
// the streamed file bytes are compared with the LCG stream
`timescale 1ns/10ps

module tb_fat_file_reader import fat_pkg::*; ();

    localparam int          ROWS = 6;
    localparam logic [31:0] SEED = 32'h9dc0f4b1;
    localparam int          RESV = 32;   // reserved sectors before the first FAT
    localparam int          SPF  = 16;   // sectors per FAT, two FATs
    localparam int          PART = 64;   // partition start behind an MBR

    typedef struct {
        logic        mbr;
        logic [15:0] bps;
        logic [7:0]  spc;
        logic [7:0]  tag;        // byte 56 of the volume record
        short_name_t name;
        logic        present;
        int          size;
        logic        frag;
        logic        exp_found;
        fs_type_e    exp_fs;
        int          exp_count;
    } row_t;

    logic         clk;
    logic         rst_n;
    short_name_t  target_name;
    sector_req_t  sector_req;
    logic         sector_done;
    sector_beat_t beat;
    fs_type_e     fs_type;
    fat_state_e   fat_state;
    logic         file_found;
    logic         out_valid;
    logic [7:0]   out_byte;

    row_t         rows [ROWS];
    int           row_idx;
    int           checks;
    int           errors;
    int           rx_count;  // file bytes seen in this row
    logic [31:0]  rx_rand;

    fat_file_reader i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .target_name (target_name),
        .sector_req  (sector_req),
        .sector_done (sector_done),
        .beat        (beat),
        .fs_type     (fs_type),
        .fat_state   (fat_state),
        .file_found  (file_found),
        .out_valid   (out_valid),
        .out_byte    (out_byte)
    );

    sector_source_model i_src (
        .clk         (clk),
        .rst_n       (rst_n),
        .sector_req  (sector_req),
        .beat        (beat),
        .sector_done (sector_done)
    );

    bind fat_file_reader fat_reader_sva i_sva (
        .clk         (clk),
        .rst_n       (rst_n),
        .sector_req  (sector_req),
        .sector_done (sector_done),
        .fat_state   (fat_state),
        .out_valid   (out_valid)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // data area starts after the reserved area and both FATs
    function automatic logic [31:0] data_lba(input logic [31:0] vol, input int spc,
                                             input int c, input int ofs);
        return vol + RESV + 2 * SPF + spc * (c - 2) + ofs;
    endfunction

    task automatic put_le(input logic [31:0] sec, input int ofs, input logic [31:0] v,
                          input int n);
        for (int i = 0; i < n; i++) begin
            i_src.write_byte(sec * 32'd512 + 32'(ofs + i), v[8*i +: 8]);
        end
    endtask

    task automatic set_fat(input logic [31:0] vol, input int c, input logic [31:0] v);
        put_le(vol + RESV + c / 128, (c % 128) * 4, v, 4);
    endtask

    // short name goes to disk in upper case and E5 marks a deleted slot
    task automatic put_entry(input logic [31:0] sec, input int slot, input short_name_t nm,
                             input logic deleted, input int cl, input int size);
        logic [7:0] ch;
        for (int i = 0; i < SHORT_NAME_LEN; i++) begin
            ch = nm[SHORT_NAME_LEN-1-i];
            if (ch >= "a" && ch <= "z") begin
                ch = ch - 8'd32;
            end
            if (i == 0 && deleted) begin
                ch = 8'hE5;
            end
            put_le(sec, slot * 32 + i, ch, 1);
        end
        put_le(sec, slot * 32 + 11, 32'h20, 1);  // archive attribute
        put_le(sec, slot * 32 + 20, cl >> 16, 2);
        put_le(sec, slot * 32 + 26, cl, 2);
        put_le(sec, slot * 32 + 28, size, 4);
    endtask

    task automatic build_image(input row_t r);
        logic [31:0] vol;
        logic [31:0] s;
        int          clus_bytes;
        int          n_cl;
        int          cl [$];
        vol        = r.mbr ? PART : 0;
        clus_bytes = 512 * r.spc;
        i_src.clear_image();
        if (r.mbr) begin
            put_le(0, 'h1C6, PART, 4);
            put_le(0, 'h1FE, 16'hAA55, 2);
        end
        put_le(vol, 'h00, 32'h0090_58EB, 3);  // EB 58 90
        put_le(vol, 'h0B, r.bps, 2);
        put_le(vol, 'h0D, r.spc, 1);
        put_le(vol, 'h0E, RESV, 2);
        put_le(vol, 'h10, 2, 1);
        put_le(vol, 'h24, SPF, 4);
        put_le(vol, 'h2C, 2, 4);              // root directory at cluster 2
        put_le(vol, 'h52, 32'h3354_4146, 4);  // "FAT3", tag follows
        put_le(vol, 'h56, r.tag, 1);
        put_le(vol, 'h1FE, 16'hAA55, 2);
        // root directory spans clusters 2 and 5
        set_fat(vol, 2, 5);
        set_fat(vol, 5, 32'h0FFF_FFF8);
        put_entry(data_lba(vol, r.spc, 2, 0), 0, "README  TXT", 1'b0, 40, 12);
        put_entry(data_lba(vol, r.spc, 5, 0), 0, r.name, 1'b1, 50, r.size);
        if (r.present) begin
            put_entry(data_lba(vol, r.spc, 5, 0), 1, r.name, 1'b0, 10, r.size);
        end
        n_cl = (r.size + clus_bytes - 1) / clus_bytes;
        for (int i = 0; i < n_cl; i++) begin
            cl.push_back(10 + i * (r.frag ? 3 : 1));
        end
        for (int i = 0; i < n_cl; i++) begin
            if (i == n_cl - 1) begin
                set_fat(vol, cl[i], 32'hFFFF_FFFF);  // top nibble is masked off
            end else begin
                set_fat(vol, cl[i], cl[i+1]);
            end
        end
        s = SEED;
        for (int k = 0; k < r.size; k++) begin
            s = lcg_next(s);
            put_le(data_lba(vol, r.spc, cl[k / clus_bytes], (k % clus_bytes) / 512),
                   k % 512, s[7:0], 1);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: row %0d file byte %0d got %h expected %h",
                     $time, row_idx, idx, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: row %0d byte count %0d expected %0d",
                     $time, row_idx, got, exp);
        end
    endtask

    task automatic check_found(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: row %0d file_found %b expected %b",
                     $time, row_idx, got, exp);
        end
    endtask

    task automatic check_fs(input fs_type_e got, input fs_type_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: row %0d fs_type %s expected %s",
                     $time, row_idx, got.name(), exp.name());
        end
    endtask

    task automatic check_state(input fat_state_e got, input fat_state_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: row %0d fat_state %s expected %s",
                     $time, row_idx, got.name(), exp.name());
        end
    endtask

    task automatic check_req(input sector_req_t got, input sector_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: row %0d sector_req %b/%0d expected %b/%0d",
                     $time, row_idx, got.start, got.sector_no, exp.start, exp.sector_no);
        end
    endtask

    // compare each file byte with the LCG stream
    always @(negedge clk) begin
        if (!rst_n && out_valid) begin
            rx_rand = lcg_next(rx_rand);
            check_byte(out_byte, rx_rand[7:0], rx_count);
            rx_count++;
        end
    end

    initial begin
        repeat (ROWS * 200_000) @(posedge clk);
        $display("timeout: fat_state did not reach ST_DONE within %0d cycles", ROWS * 200_000);
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b1;  // reset asserted
        target_name = '0;
        checks      = 0;
        errors      = 0;
        rows = '{
            '{1'b0, 16'd512,  8'd1, "2", "Data    Bin", 1'b1, 1436, 1'b1, 1'b1, FS_FAT32, 1436},
            '{1'b1, 16'd512,  8'd2, "2", "Log     Dat", 1'b1, 2000, 1'b0, 1'b1, FS_FAT32, 2000},
            '{1'b0, 16'd512,  8'd4, "2", "notes   txt", 1'b1, 2100, 1'b1, 1'b1, FS_FAT32, 2100},
            '{1'b0, 16'd512,  8'd1, "2", "Gone    Tmp", 1'b0, 300, 1'b0, 1'b0, FS_FAT32, 0},
            '{1'b0, 16'd1024, 8'd1, "2", "Data    Bin", 1'b1, 300, 1'b0, 1'b0, FS_UNASSIGNED, 0},
            '{1'b0, 16'd512,  8'd1, "6", "Data    Bin", 1'b1, 300, 1'b0, 1'b0, FS_UNKNOWN, 0}
        };
        for (int r = 0; r < ROWS; r++) begin
            @(posedge clk);
            rst_n       <= 1'b1;
            target_name <= rows[r].name;
            row_idx  = r;
            rx_count = 0;
            rx_rand  = SEED;
            build_image(rows[r]);
            repeat (9) @(posedge clk);
            @(negedge clk);
            check_state(fat_state, ST_RESET);
            check_fs(fs_type, FS_UNASSIGNED);
            check_found(file_found, 1'b0);
            check_req(sector_req, '0);
            @(posedge clk);
            rst_n <= 1'b0;
            // first read of sector 0 starts one cycle after release
            repeat (2) @(negedge clk);
            check_state(fat_state, ST_SEARCH_MBR);
            check_req(sector_req, {1'b1, 32'd0});
            while (fat_state != ST_DONE) begin
                @(negedge clk);
            end
            repeat (4) @(negedge clk);
            check_state(fat_state, ST_DONE);
            check_found(file_found, rows[r].exp_found);
            check_fs(fs_type, rows[r].exp_fs);
            check_count(rx_count, rows[r].exp_count);
        end
        errors = errors + i_dut.i_sva.fail_count;
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- src.f
hw/fat_pkg.sv
hw/boot_sector_parser.sv
hw/dir_entry_matcher.sv
hw/cluster_walker.sv
hw/file_byte_streamer.sv
hw/fat_file_reader.sv
bench/sector_source_model.sv
bench/fat_reader_sva.sv
bench/tb_fat_file_reader.sv

//--- Bender.yml
package:
  name: fat_file_reader

sources:
  - hw/fat_pkg.sv
  - hw/boot_sector_parser.sv
  - hw/dir_entry_matcher.sv
  - hw/cluster_walker.sv
  - hw/file_byte_streamer.sv
  - hw/fat_file_reader.sv
  - target: test
    files:
      - bench/sector_source_model.sv
      - bench/fat_reader_sva.sv
      - bench/tb_fat_file_reader.sv
